// ==== logic/mem_pkg.sv ====
`default_nettype none

// ------------------------------
// Shared sizes and types for the list-select scheduler storage
// ------------------------------

package mem_pkg;

    // Default geometry of the register file, overridden from the top level
    localparam int unsigned rf_depth_default = 4;
    localparam int unsigned rf_width_default = 10;

    // Flops in the reset synchronizer chain on rclk
    // The synchronized reset releases this many rclk edges after rst_n rises
    localparam int unsigned sync_stages = 2;

    // Delay of the modelled power switch, counted in rclk cycles
    // pwr_enable_b_out trails pwr_enable_b_in by exactly this amount
    localparam int unsigned pg_chain_delay = 2;

    // ------------------------------
    // Power-gating controller states
    // ------------------------------

    // Sleep walks down the list, wake walks back up through switch_on and release
    // Encoding is plain binary, three bits cover all six states
    typedef enum logic [2:0] {
        pg_on         = 3'd0,
        pg_isolate    = 3'd1,
        pg_switch_off = 3'd2,
        pg_off        = 3'd3,
        pg_switch_on  = 3'd4,
        pg_release    = 3'd5
    } pg_state_e;

endpackage

`default_nettype wire

// ==== logic/mem_reset_sync_scan.sv ====
`default_nettype none

// Reset synchronizer for the read clock domain of the register file
// Assertion of the reset is asynchronous, release is synchronous to rclk
// A scan mode bypass lets the tester drive the reset directly

module mem_reset_sync_scan (
     input  logic rclk
    ,input  logic rst_n

    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b

    ,output logic rst_n_sync
);

    // Shift chain that walks a one in from the bottom after reset is released
    logic [mem_pkg::sync_stages-1:0] sync_q;

    // ------------------------------
    // Synchronizer chain
    // ------------------------------

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            // Stage zero samples a constant one, the rest shift it along
            sync_q[0] <= 1'b1;
            for (int i = 1; i < int'(mem_pkg::sync_stages); i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // In scan mode the tester owns the reset, otherwise the last stage drives it
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[mem_pkg::sync_stages-1];

    // ------------------------------
    // Checks
    // ------------------------------

    // Outside scan mode, the synchronized reset must stay low while the raw reset is low
    a_no_early_release : assert property (
        @(posedge rclk) (!rst_n && !fscan_rstbypen) |-> !rst_n_sync
    ) else $error("mem_reset_sync_scan: rst_n_sync high while rst_n low and bypass off");

endmodule

`default_nettype wire

// ==== logic/rf_2clk_array.sv ====
`default_nettype none

// Behavioral two-clock register file
// Writes land on wclk, reads are registered on rclk with one cycle of latency
// A short delay chain stands in for the power switch, and isolation clamps the output

module rf_2clk_array #(
     parameter  int DEPTH  = mem_pkg::rf_depth_default
    ,parameter  int WIDTH  = mem_pkg::rf_width_default
    ,localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
     input  logic              wclk
    ,input  logic              we
    ,input  logic [ADDR_W-1:0] waddr
    ,input  logic [WIDTH-1:0]  wdata

    ,input  logic              rclk
    ,input  logic              re
    ,input  logic [ADDR_W-1:0] raddr
    ,output logic [WIDTH-1:0]  rdata

    // Synchronized reset from the wrapper, rclk domain
    ,input  logic              rst_n

    // Power management
    ,input  logic              isol_en
    ,input  logic              pwr_enable_b_in
    ,output logic              pwr_enable_b_out
);

    // Contents are undefined after power-up until each entry is rewritten
    logic [WIDTH-1:0] mem_q [DEPTH];

    // Registered read data before the isolation clamp
    logic [WIDTH-1:0] rdata_q;

    // One flop per cycle of switch delay
    logic [mem_pkg::pg_chain_delay-1:0] pwr_chain_q;

    // Array is usable only when the switch reports on and isolation is off
    logic array_live;
    logic wr_ok;
    logic rd_ok;

    assign array_live = !pwr_enable_b_out && !isol_en;
    assign wr_ok      = we && rst_n && array_live;
    assign rd_ok      = re && array_live;

    // ------------------------------
    // Power switch model
    // ------------------------------

    // Enable is active low, so a one travelling down the chain means the array turns off
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_chain_q <= '0;
        end else begin
            pwr_chain_q[0] <= pwr_enable_b_in;
            for (int i = 1; i < int'(mem_pkg::pg_chain_delay); i++) begin
                pwr_chain_q[i] <= pwr_chain_q[i-1];
            end
        end
    end

    assign pwr_enable_b_out = pwr_chain_q[mem_pkg::pg_chain_delay-1];

    // ------------------------------
    // Write port
    // ------------------------------

    // Writes that arrive while isolated, switched off or in reset are dropped
    always_ff @(posedge wclk) begin
        if (wr_ok) begin
            mem_q[waddr] <= wdata;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (isol_en) begin
            // Flush the old word so nothing stale shows once isolation drops
            rdata_q <= '0;
        end else if (rd_ok) begin
            rdata_q <= mem_q[raddr];
        end
    end

    // Clamp keeps the floating array output away from downstream logic
    assign rdata = isol_en ? '0 : rdata_q;

    // Addresses beyond the last entry are illegal on either port
    a_waddr_range : assert property (
        @(posedge wclk) disable iff (!rst_n) we |-> (int'(waddr) < DEPTH)
    ) else $error("rf_2clk_array: write address %0d out of range", waddr);

    a_raddr_range : assert property (
        @(posedge rclk) disable iff (!rst_n) re |-> (int'(raddr) < DEPTH)
    ) else $error("rf_2clk_array: read address %0d out of range", raddr);

endmodule

`default_nettype wire

// ==== logic/rf_pg_wrapper.sv ====
`default_nettype none

// Power-gated register file wrapper for the list-select storage
// Brings the IP reset onto rclk and hands it to the array
// Isolation and the power enable chain pass through to the array untouched

module rf_pg_wrapper #(
     parameter  int DEPTH  = mem_pkg::rf_depth_default
    ,parameter  int WIDTH  = mem_pkg::rf_width_default
    ,localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
     input  logic              wclk
    ,input  logic              we
    ,input  logic [ADDR_W-1:0] waddr
    ,input  logic [WIDTH-1:0]  wdata

    ,input  logic              rclk
    ,input  logic              re
    ,input  logic [ADDR_W-1:0] raddr
    ,output logic [WIDTH-1:0]  rdata

    // Power interface from the gating controller
    ,input  logic              isol_en
    ,input  logic              pwr_enable_b_in
    ,output logic              pwr_enable_b_out

    // IP reset, raw and asynchronous
    ,input  logic              rst_n

    // Scan reset control
    ,input  logic              fscan_rstbypen
    ,input  logic              fscan_byprst_b
);

    // IP reset after the synchronizer, or the scan reset in bypass mode
    logic rst_n_sync;

    // ------------------------------
    // Reset synchronizer
    // ------------------------------

    // The array keeps its control flops on rclk, so that is where reset is released
    mem_reset_sync_scan i_rst_sync (
         .rclk            (rclk)
        ,.rst_n           (rst_n)
        ,.fscan_rstbypen  (fscan_rstbypen)
        ,.fscan_byprst_b  (fscan_byprst_b)
        ,.rst_n_sync      (rst_n_sync)
    );

    // ------------------------------
    // Register file array
    // ------------------------------

    rf_2clk_array #(
         .DEPTH             (DEPTH)
        ,.WIDTH             (WIDTH)
    ) i_rf (
         .wclk              (wclk)
        ,.we                (we)
        ,.waddr             (waddr)
        ,.wdata             (wdata)

        ,.rclk              (rclk)
        ,.re                (re)
        ,.raddr             (raddr)
        ,.rdata             (rdata)

        ,.rst_n             (rst_n_sync)

        ,.isol_en           (isol_en)
        ,.pwr_enable_b_in   (pwr_enable_b_in)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
    );

endmodule

`default_nettype wire

// ==== logic/mem_pg_ctrl.sv ====
`default_nettype none

// Power-gating sequencer for the register file
// Going to sleep isolates first, then opens the switch, then acknowledges
// Waking closes the switch, waits for it to report, then drops isolation and the acknowledge

module mem_pg_ctrl (
     input  logic rclk
    ,input  logic rst_n

    // Level request from the scheduler, high asks for sleep
    ,input  logic sleep_req

    // Switch status returned through the array's delay chain
    ,input  logic pwr_enable_b_out

    ,output logic isol_en
    ,output logic pwr_enable_b
    ,output logic sleep_ack
);

    mem_pkg::pg_state_e state_q;
    mem_pkg::pg_state_e state_d;

    // Outputs come straight from flops so nothing glitches into the array
    logic isol_en_q;
    logic pwr_enable_b_q;
    logic sleep_ack_q;

    // ------------------------------
    // Next state
    // ------------------------------

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            mem_pkg::pg_on: begin
                // A request that came in mid-sequence is picked up here, once back on
                if (sleep_req) begin
                    state_d = mem_pkg::pg_isolate;
                end
            end
            mem_pkg::pg_isolate: begin
                // Isolation has been up for a cycle, safe to cut power
                state_d = mem_pkg::pg_switch_off;
            end
            mem_pkg::pg_switch_off: begin
                if (pwr_enable_b_out) begin
                    state_d = mem_pkg::pg_off;
                end
            end
            mem_pkg::pg_off: begin
                if (!sleep_req) begin
                    state_d = mem_pkg::pg_switch_on;
                end
            end
            mem_pkg::pg_switch_on: begin
                // Hold isolation until the switch confirms the array is powered
                if (!pwr_enable_b_out) begin
                    state_d = mem_pkg::pg_release;
                end
            end
            mem_pkg::pg_release: begin
                state_d = mem_pkg::pg_on;
            end
            default: begin
                state_d = mem_pkg::pg_on;
            end
        endcase
    end

    // ------------------------------
    // State and output registers
    // ------------------------------

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= mem_pkg::pg_on;
            isol_en_q      <= 1'b0;
            pwr_enable_b_q <= 1'b0;
            sleep_ack_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            // Isolation covers everything between leaving on and reaching release
            isol_en_q <= (state_d != mem_pkg::pg_on) && (state_d != mem_pkg::pg_release);
            // Switch stays open only while going to or sitting in off
            pwr_enable_b_q <= (state_d == mem_pkg::pg_switch_off) ||
                              (state_d == mem_pkg::pg_off);
            // Ack holds from off until release so it falls together with isolation
            sleep_ack_q <= (state_d == mem_pkg::pg_off) ||
                           (state_d == mem_pkg::pg_switch_on);
        end
    end

    assign isol_en      = isol_en_q;
    assign pwr_enable_b = pwr_enable_b_q;
    assign sleep_ack    = sleep_ack_q;

    // Powering down with the outputs unclamped would drive garbage downstream
    a_pwr_needs_isol : assert property (
        @(posedge rclk) disable iff (!rst_n) pwr_enable_b |-> isol_en
    ) else $error("mem_pg_ctrl: power off without isolation, state %0d (%0d bits)",
                  state_q, $bits(mem_pkg::pg_state_e));

    a_ack_needs_isol : assert property (
        @(posedge rclk) disable iff (!rst_n) sleep_ack |-> isol_en
    ) else $error("mem_pg_ctrl: sleep_ack without isolation, state %0d (%0d bits)",
                  state_q, $bits(mem_pkg::pg_state_e));

endmodule

`default_nettype wire

// ==== logic/list_sel_mem_top.sv ====
`default_nettype none

// Storage top for the list-select scheduler
// Pairs the power-gating controller with the wrapped register file
// Geometry is chosen here and passed down to the array

module list_sel_mem_top #(
     parameter  int DEPTH  = mem_pkg::rf_depth_default
    ,parameter  int WIDTH  = mem_pkg::rf_width_default
    ,localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
     input  logic              wclk
    ,input  logic              rclk
    ,input  logic              rst_n

    // Write side, wclk domain
    ,input  logic              we
    ,input  logic [ADDR_W-1:0] waddr
    ,input  logic [WIDTH-1:0]  wdata

    // Read side, rclk domain
    ,input  logic              re
    ,input  logic [ADDR_W-1:0] raddr
    ,output logic [WIDTH-1:0]  rdata

    // Sleep handshake levels, rclk domain
    ,input  logic              sleep_req
    ,output logic              sleep_ack

    ,input  logic              fscan_rstbypen
    ,input  logic              fscan_byprst_b
);

    // ------------------------------
    // Power control nets
    // ------------------------------

    logic isol_en;
    logic pwr_enable_b;
    // Switch status from the far end of the array's chain
    logic pwr_enable_b_out;

    // Controller sits on the raw reset, the array gets its own synchronized copy
    mem_pg_ctrl i_pg_ctrl (
         .rclk              (rclk)
        ,.rst_n             (rst_n)
        ,.sleep_req         (sleep_req)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.isol_en           (isol_en)
        ,.pwr_enable_b      (pwr_enable_b)
        ,.sleep_ack         (sleep_ack)
    );

    rf_pg_wrapper #(
         .DEPTH             (DEPTH)
        ,.WIDTH             (WIDTH)
    ) i_rf_pg (
         .wclk              (wclk)
        ,.we                (we)
        ,.waddr             (waddr)
        ,.wdata             (wdata)

        ,.rclk              (rclk)
        ,.re                (re)
        ,.raddr             (raddr)
        ,.rdata             (rdata)

        ,.isol_en           (isol_en)
        ,.pwr_enable_b_in   (pwr_enable_b)
        ,.pwr_enable_b_out  (pwr_enable_b_out)

        ,.rst_n             (rst_n)
        ,.fscan_rstbypen    (fscan_rstbypen)
        ,.fscan_byprst_b    (fscan_byprst_b)
    );

endmodule

`default_nettype wire

// ==== tests/tb_list_sel_mem.sv ====
`default_nettype none

module tb_list_sel_mem;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int D  = mem_pkg::rf_depth_default;
    localparam int W  = mem_pkg::rf_width_default;
    localparam int AW = (D > 1) ? $clog2(D) : 1;

    // Rough upper bound of each test in rclk cycles, in run order
    localparam int run_cycles    = 20 + 40 + 40 + 60 + 60 + 80;
    localparam int margin_cycles = 200;

    logic          wclk;
    logic          rclk;
    logic          rst_n;
    logic          we;
    logic [AW-1:0] waddr;
    logic [W-1:0]  wdata;
    logic          re;
    logic [AW-1:0] raddr;
    logic [W-1:0]  rdata;
    logic          sleep_req;
    logic          sleep_ack;
    logic          fscan_rstbypen;
    logic          fscan_byprst_b;

    // Scoreboard of what each entry should hold
    logic [W-1:0]  sb [D];
    // Word the pending read must return, or must not return while ban_chk is high
    logic [W-1:0]  rd_expect;
    logic          ban_chk;
    logic [W-1:0]  hold_val;
    logic          hold_chk;
    logic [15:0]   lfsr;
    int            rst_cycles;
    int            ack_wait;
    int            errors;
    int            err_mark;
    int            tests_run;
    string         test_name;

    list_sel_mem_top #(
         .DEPTH           (D)
        ,.WIDTH           (W)
    ) dut0 (
         .wclk            (wclk)
        ,.rclk            (rclk)
        ,.rst_n           (rst_n)
        ,.we              (we)
        ,.waddr           (waddr)
        ,.wdata           (wdata)
        ,.re              (re)
        ,.raddr           (raddr)
        ,.rdata           (rdata)
        ,.sleep_req       (sleep_req)
        ,.sleep_ack       (sleep_ack)
        ,.fscan_rstbypen  (fscan_rstbypen)
        ,.fscan_byprst_b  (fscan_byprst_b)
    );

    // ------------------------------
    // Clocks and bookkeeping
    // ------------------------------

    initial begin
        rclk = 1'b0;
        forever #4 rclk = ~rclk;
    end

    // Same period as rclk, shifted by 3 ns so the two domains never line up
    initial begin
        wclk = 1'b0;
        #3;
        forever #4 wclk = ~wclk;
    end

    // Cycles since reset release, and cycles that sleep_ack has lagged sleep_req
    always @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rst_cycles <= 0;
            ack_wait   <= 0;
        end else begin
            if (rst_cycles < 100) begin
                rst_cycles <= rst_cycles + 1;
            end
            ack_wait <= (sleep_req == sleep_ack) ? 0 : ack_wait + 1;
        end
    end

    initial begin
        #((run_cycles + margin_cycles) * 8);
        $display("Watchdog expired after %0d rclk cycles, run stopped",
                 run_cycles + margin_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic log_mismatch(input string check, input logic [31:0] exp,
                                input logic [31:0] act);
        errors++;
        $display("CHECK FAILED %s (%s): expected %0h actual %0h at %0t",
                 test_name, check, exp, act, $time);
    endtask

    // The word lands on the second wclk edge of the task
    task automatic write_word(input int a, input logic [W-1:0] d);
        @(posedge wclk);
        #1;
        we    = 1'b1;
        waddr = AW'(a);
        wdata = d;
        @(posedge wclk);
        #1;
        we = 1'b0;
    endtask

    task automatic write_random(input int a);
        logic [31:0] r;
        draw_bits(W, r);
        write_word(a, r[W-1:0]);
        sb[a] = r[W-1:0];
    endtask

    // Single read, the assertions compare rdata one rclk after re
    task automatic do_read(input int a, input logic [W-1:0] value, input logic must_differ);
        @(posedge rclk);
        #1;
        re        = 1'b1;
        raddr     = AW'(a);
        rd_expect = value;
        ban_chk   = must_differ;
        @(posedge rclk);
        #1;
        re = 1'b0;
        @(posedge rclk);
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (sleep_ack !== level && n < 12) begin
            @(posedge rclk);
            #1;
            n++;
        end
        if (sleep_ack !== level) begin
            errors++;
            $display("sleep_ack never reached %0b within %0d rclk cycles", level, n);
        end
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %s: %s, %0d new errors", test_name,
                 (errors == err_mark) ? "ok" : "mismatches", errors - err_mark);
        err_mark = errors;
    endtask

    // ------------------------------
    // Checks
    // ------------------------------

    a_reset_quiet : assert property (@(posedge rclk)
        (rst_cycles <= int'(mem_pkg::sync_stages)) |-> (rdata == '0 && !sleep_ack))
        else log_mismatch("reset outputs", 0, 32'({sleep_ack, rdata}));

    a_read : assert property (@(posedge rclk) disable iff (!rst_n)
        (re && !ban_chk) |=> (rdata == rd_expect))
        else log_mismatch("read data", 32'(rd_expect), 32'(rdata));

    a_no_leak : assert property (@(posedge rclk) disable iff (!rst_n)
        (re && ban_chk) |=> (rdata != rd_expect))
        else log_mismatch("sleep write must not appear", 32'(rd_expect), 32'(rdata));

    a_hold : assert property (@(posedge rclk) disable iff (!rst_n)
        hold_chk |-> (rdata == hold_val))
        else log_mismatch("held rdata", 32'(hold_val), 32'(rdata));

    // The acknowledge only stands while isolation is up, so the read port must show zero
    a_isolated_zero : assert property (@(posedge rclk) disable iff (!rst_n)
        sleep_ack |-> (rdata == '0))
        else log_mismatch("clamp while asleep", 0, 32'(rdata));

    a_ack_bound : assert property (@(posedge rclk) disable iff (!rst_n)
        ack_wait <= 10)
        else log_mismatch("sleep_ack level", 32'(sleep_req), 32'(sleep_ack));

    a_scan_zero : assert property (@(posedge rclk)
        (fscan_rstbypen && !fscan_byprst_b) |-> (rdata == '0))
        else log_mismatch("rdata in scan reset", 0, 32'(rdata));

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        we             = 1'b0;
        waddr          = '0;
        wdata          = '0;
        re             = 1'b0;
        raddr          = '0;
        sleep_req      = 1'b0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        rst_n          = 1'b1;
        rd_expect      = '0;
        ban_chk        = 1'b0;
        hold_val       = '0;
        hold_chk       = 1'b0;
        lfsr           = 16'd18;
        errors         = 0;
        err_mark       = 0;
        tests_run      = 0;

        // Clean falling edge on rst_n before the first rclk edge
        test_name = "reset";
        #1;
        rst_n = 1'b0;
        repeat (8) @(posedge rclk);
        #1;
        rst_n = 1'b1;
        repeat (mem_pkg::sync_stages + 2) @(posedge rclk);
        end_test();

        test_name = "write_read";
        for (int a = 0; a < D; a++) begin
            write_random(a);
            repeat (2) @(posedge rclk);
            do_read(a, sb[a], 1'b0);
        end
        end_test();

        // rdata is loaded from entry 0, then every entry changes underneath it
        test_name = "hold";
        do_read(0, sb[0], 1'b0);
        @(posedge rclk);
        #1;
        hold_val = sb[0];
        hold_chk = 1'b1;
        for (int a = 0; a < D; a++) begin
            write_random(a);
        end
        repeat (2) @(posedge rclk);
        #1;
        hold_chk = 1'b0;
        for (int a = 0; a < D; a++) begin
            do_read(a, sb[a], 1'b0);
        end
        end_test();

        // Writes while asleep carry the inverse of each stored word
        test_name = "sleep";
        @(posedge rclk);
        #1;
        sleep_req = 1'b1;
        wait_ack(1'b1);
        for (int a = 0; a < D; a++) begin
            write_word(a, ~sb[a]);
        end
        for (int a = 0; a < D; a++) begin
            do_read(a, '0, 1'b0);
        end
        @(posedge rclk);
        #1;
        sleep_req = 1'b0;
        wait_ack(1'b0);
        end_test();

        test_name = "wake";
        for (int a = 0; a < D; a++) begin
            do_read(a, ~sb[a], 1'b1);
            write_random(a);
            repeat (2) @(posedge rclk);
            do_read(a, sb[a], 1'b0);
        end
        end_test();

        // Scan reset held low, so writes are dropped and reads stay at zero
        test_name = "scan";
        @(posedge rclk);
        #1;
        fscan_rstbypen = 1'b1;
        fscan_byprst_b = 1'b0;
        for (int a = 0; a < D; a++) begin
            write_word(a, ~sb[a]);
        end
        for (int a = 0; a < D; a++) begin
            do_read(a, '0, 1'b0);
        end
        @(posedge rclk);
        #1;
        fscan_byprst_b = 1'b1;
        fscan_rstbypen = 1'b0;
        for (int a = 0; a < D; a++) begin
            write_random(a);
            repeat (2) @(posedge rclk);
            do_read(a, sb[a], 1'b0);
        end
        end_test();

        $display("%0d tests run, %0d checks failed", tests_run, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/mem_pkg.sv
logic/mem_reset_sync_scan.sv
logic/rf_2clk_array.sv
logic/rf_pg_wrapper.sv
logic/mem_pg_ctrl.sv
logic/list_sel_mem_top.sv
tests/tb_list_sel_mem.sv

// ==== Makefile ====
# Verilator build for the list-select storage testbench

VERILATOR ?= verilator
TOP       ?= tb_list_sel_mem
FILELIST  ?= project.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# A run that aborts early never prints the pass line, so that counts as a failure too
sim: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
